// File: src/mf2_pkg.sv
// Multiface Two shared definitions
`default_nettype none

package mf2_pkg;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;
	typedef logic [12:0] mf2_ram_addr_t;   // 8 KB shadow RAM
	typedef logic [4:0]  pen_index_t;      // Bit 4 selects the border
	typedef logic [3:0]  crtc_reg_t;
	typedef logic [1:0]  mf2_mode_t;       // 0 enabled, bit 1 disabled

	typedef enum logic [2:0] {
		OFF_VISIBLE,
		OFF_HIDDEN,
		NMI_PENDING,
		ACTIVE,
		ACTIVE_HIDDEN
	} mf2_state_t;

	// Opcode fetch addresses
	localparam cpu_addr_t NMI_VECTOR  = 16'h0066;
	localparam cpu_addr_t HIDE_VECTOR = 16'h0065;

	// FEE8h/FEEAh, compared on address bits 15:2
	localparam logic [13:0] CTRL_PORT_BASE = 14'h3fba;

	//////////////////////////////////////////////////////////////////////
	// Shadow slots inside the RAM
	localparam mf2_ram_addr_t SLOT_PEN_SELECT  = 13'h1fcf;
	localparam mf2_ram_addr_t SLOT_PEN_BASE    = 13'h1f90;
	localparam mf2_ram_addr_t SLOT_BORDER      = 13'h1fdf;
	localparam mf2_ram_addr_t SLOT_MODE        = 13'h1fef;
	localparam mf2_ram_addr_t SLOT_BANKING     = 13'h1fff;
	localparam mf2_ram_addr_t SLOT_CRTC_SELECT = 13'h1cff;
	localparam mf2_ram_addr_t SLOT_CRTC_BASE   = 13'h1db0;
	localparam mf2_ram_addr_t SLOT_PPI         = 13'h17ff;
	localparam mf2_ram_addr_t SLOT_UPPER_ROM   = 13'h1aac;

	// Port high address bytes
	localparam cpu_data_t PORT_GA        = 8'h7f;
	localparam cpu_data_t PORT_CRTC_SEL  = 8'hbc;
	localparam cpu_data_t PORT_CRTC_DATA = 8'hbd;
	localparam cpu_data_t PORT_PPI       = 8'hf7;
	localparam cpu_data_t PORT_ROM_SEL   = 8'hdf;

endpackage

`default_nettype wire

// File: src/mf2_bus_if.sv
// Multiface CPU bus bundle
`timescale 1ns/1ps
`default_nettype none

interface mf2_bus_if;

	mf2_pkg::cpu_addr_t addr;
	mf2_pkg::cpu_data_t wdata;   // CPU write data
	logic               m1;
	logic               io_wr;   // iorq and wr together
	logic               mem_rd;
	logic               mem_wr;

	// Event detection side
	modport monitor (
		input addr,
		input wdata,
		input m1,
		input io_wr
	);

	// Shadow store and RAM side
	modport shadow (
		input addr,
		input wdata,
		input io_wr,
		input mem_wr,
		input mem_rd
	);

endinterface

`default_nettype wire

// File: src/mf2_bus_monitor.sv
// Multiface bus event monitor
`timescale 1ns/1ps
`default_nettype none

module mf2_bus_monitor (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	mf2_bus_if.monitor      bus,
	input  wire logic       key_nmi,
	output logic            freeze_evt,
	output logic            vector_evt,
	output logic            hide_evt,
	output logic            page_in_evt,
	output logic            page_out_evt,
	output logic            io_write_evt
);

	logic m1_q;
	logic io_wr_q;
	logic key_nmi_q;
	logic m1_rise;
	logic io_wr_rise;
	logic ctrl_hit;

	//////////////////////////////////////////////////////////////////////
	// One cycle of history for edge detection

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m1_q      <= 1'b0;
			io_wr_q   <= 1'b0;
			key_nmi_q <= 1'b0;
		end else begin
			m1_q      <= bus.m1;
			io_wr_q   <= bus.io_wr;
			key_nmi_q <= key_nmi;
		end
	end

	assign m1_rise    = bus.m1 & ~m1_q;
	assign io_wr_rise = bus.io_wr & ~io_wr_q;

	// Control port pair FEE8h/FEEAh
	assign ctrl_hit = (bus.addr[15:2] == mf2_pkg::CTRL_PORT_BASE);

	//////////////////////////////////////////////////////////////////////
	// Single-cycle events

	assign freeze_evt = key_nmi & ~key_nmi_q;   // Button pressed

	// Opcode fetch at the NMI entry or at the hide address
	assign vector_evt = m1_rise & (bus.addr == mf2_pkg::NMI_VECTOR);
	assign hide_evt   = m1_rise & (bus.addr == mf2_pkg::HIDE_VECTOR);

	// Address bit 1 tells page in from page out
	assign page_in_evt  = io_wr_rise & ctrl_hit & ~bus.addr[1];
	assign page_out_evt = io_wr_rise & ctrl_hit & bus.addr[1];

	// Everything else may be a shadowed hardware register
	assign io_write_evt = io_wr_rise & ~ctrl_hit;

endmodule

`default_nettype wire

// File: src/mf2_paging_fsm.sv
// Multiface paging state machine
`timescale 1ns/1ps
`default_nettype none

module mf2_paging_fsm (
	input  wire logic                clk_sys,
	input  wire logic                reset,
	input  wire mf2_pkg::mf2_mode_t  mode,
	input  wire logic                freeze_evt,
	input  wire logic                vector_evt,
	input  wire logic                hide_evt,
	input  wire logic                page_in_evt,
	input  wire logic                page_out_evt,
	input  wire logic [2:0]          window_sel,   // cpu_addr[15:13]
	output logic                     nmi,
	output logic                     mf2_active,
	output logic                     rom_en,
	output logic                     ram_en
);

	localparam logic [2:0] ROM_WINDOW = 3'b000;   // 0000h-1FFFh
	localparam logic [2:0] RAM_WINDOW = 3'b001;   // 2000h-3FFFh

	mf2_pkg::mf2_state_t state_q;
	mf2_pkg::mf2_state_t state_d;
	logic                disabled;

	assign disabled = mode[1];

	//////////////////////////////////////////////////////////////////////
	// Next state

	always_comb begin
		state_d = state_q;
		case (state_q)
			mf2_pkg::OFF_VISIBLE: begin
				if (freeze_evt && !disabled)
					state_d = mf2_pkg::NMI_PENDING;
				else if (page_in_evt && !disabled)
					state_d = mf2_pkg::ACTIVE;
			end
			mf2_pkg::OFF_HIDDEN: begin
				// I/O page-in is ignored here
				if (freeze_evt && !disabled)
					state_d = mf2_pkg::NMI_PENDING;
			end
			mf2_pkg::NMI_PENDING: begin
				if (vector_evt)
					state_d = mf2_pkg::ACTIVE;   // CPU took the NMI
			end
			mf2_pkg::ACTIVE: begin
				if (page_out_evt)
					state_d = mf2_pkg::OFF_VISIBLE;
				else if (hide_evt)
					state_d = mf2_pkg::ACTIVE_HIDDEN;
			end
			mf2_pkg::ACTIVE_HIDDEN: begin
				if (page_out_evt)
					state_d = mf2_pkg::OFF_HIDDEN;
			end
			default: state_d = mf2_pkg::OFF_HIDDEN;
		endcase
	end

	// Any nonzero mode comes out of reset hidden
	always_ff @(posedge clk_sys) begin
		if (reset)
			state_q <= (mode == 2'd0) ? mf2_pkg::OFF_VISIBLE : mf2_pkg::OFF_HIDDEN;
		else
			state_q <= state_d;
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs

	assign nmi = (state_q == mf2_pkg::NMI_PENDING);

	assign mf2_active = (state_q == mf2_pkg::ACTIVE) ||
	                    (state_q == mf2_pkg::ACTIVE_HIDDEN);

	// Window decode, only while paged in
	assign rom_en = mf2_active & (window_sel == ROM_WINDOW);
	assign ram_en = mf2_active & (window_sel == RAM_WINDOW);

endmodule

`default_nettype wire

// File: src/mf2_shadow_ram.sv
// Multiface shadow store and RAM
`timescale 1ns/1ps
`default_nettype none

module mf2_shadow_ram (
	input  wire logic           clk_sys,
	input  wire logic           reset,
	mf2_bus_if.shadow           bus,
	input  wire logic           io_write_evt,
	input  wire logic           ram_en,
	output mf2_pkg::cpu_data_t  dout
);

	mf2_pkg::cpu_data_t     mem [8192];
	mf2_pkg::pen_index_t    pen_index;
	mf2_pkg::crtc_reg_t     crtc_reg;
	mf2_pkg::mf2_ram_addr_t store_addr;
	logic                   store_hit;
	logic                   store_evt;
	mf2_pkg::mf2_ram_addr_t ram_addr;
	mf2_pkg::cpu_data_t     ram_wdata;
	logic                   ram_we;
	mf2_pkg::cpu_data_t     ram_rdata;

	//////////////////////////////////////////////////////////////////////
	// Port write to shadow slot

	always_comb begin
		store_hit  = 1'b1;
		store_addr = '0;
		case (bus.addr[15:8])
			mf2_pkg::PORT_GA: begin
				case (bus.wdata[7:6])   // Gate array function bits
					2'b00: store_addr = mf2_pkg::SLOT_PEN_SELECT;
					2'b01: store_addr = pen_index[4] ? mf2_pkg::SLOT_BORDER :
					                    mf2_pkg::SLOT_PEN_BASE + {9'd0, pen_index[3:0]};
					2'b10: store_addr = mf2_pkg::SLOT_MODE;
					default: store_addr = mf2_pkg::SLOT_BANKING;
				endcase
			end
			mf2_pkg::PORT_CRTC_SEL:  store_addr = mf2_pkg::SLOT_CRTC_SELECT;
			mf2_pkg::PORT_CRTC_DATA: store_addr = mf2_pkg::SLOT_CRTC_BASE + {9'd0, crtc_reg};
			mf2_pkg::PORT_PPI:       store_addr = mf2_pkg::SLOT_PPI;   // 8255 control
			mf2_pkg::PORT_ROM_SEL:   store_addr = mf2_pkg::SLOT_UPPER_ROM;
			default:                 store_hit  = 1'b0;   // No slot for this port
		endcase
	end

	assign store_evt = io_write_evt & store_hit;

	// Last selected pen and CRTC register
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index <= '0;
			crtc_reg  <= '0;
		end else if (io_write_evt) begin
			if (bus.addr[15:8] == mf2_pkg::PORT_GA && bus.wdata[7:6] == 2'b00)
				pen_index <= bus.wdata[4:0];
			if (bus.addr[15:8] == mf2_pkg::PORT_CRTC_SEL)
				crtc_reg <= bus.wdata[3:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// RAM request stage, I/O store first, then window write, then read

	always_ff @(posedge clk_sys) begin
		ram_addr  <= store_evt ? store_addr : bus.addr[12:0];   // Low 13 bits of the window
		ram_wdata <= bus.wdata;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= store_evt | (bus.mem_wr & ram_en);
	end

	// Array with registered read and write-through
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_wdata;
			ram_rdata     <= ram_wdata;
		end else begin
			ram_rdata <= mem[ram_addr];
		end
	end

	assign dout = (ram_en & bus.mem_rd) ? ram_rdata : 8'hff;   // Open bus otherwise

endmodule

`default_nettype wire

// File: src/multiface_two.sv
// Multiface Two top level
`timescale 1ns/1ps
`default_nettype none

module multiface_two (
	input  wire logic                clk_sys,
	input  wire logic                reset,
	input  wire mf2_pkg::cpu_addr_t  cpu_addr,
	input  wire mf2_pkg::cpu_data_t  cpu_dout,   // CPU write data
	input  wire logic                m1,
	input  wire logic                iorq,
	input  wire logic                rd,
	input  wire logic                wr,
	input  wire logic                mem_rd,
	input  wire logic                mem_wr,
	input  wire logic                key_nmi,    // Freeze button
	input  wire mf2_pkg::mf2_mode_t  mode,
	output logic                     nmi,
	output logic                     mf2_active,
	output logic                     rom_en,
	output logic                     ram_en,
	output mf2_pkg::cpu_data_t       dout
);

	logic freeze_evt;
	logic vector_evt;
	logic hide_evt;
	logic page_in_evt;
	logic page_out_evt;
	logic io_write_evt;

	//////////////////////////////////////////////////////////////////////
	// Internal bus

	mf2_bus_if bus ();

	assign bus.addr   = cpu_addr;
	assign bus.wdata  = cpu_dout;
	assign bus.m1     = m1;
	assign bus.io_wr  = wr & iorq;
	assign bus.mem_rd = mem_rd;
	assign bus.mem_wr = mem_wr;

	mf2_bus_monitor i_bus_monitor (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus.monitor),
		.key_nmi      (key_nmi),
		.freeze_evt   (freeze_evt),
		.vector_evt   (vector_evt),
		.hide_evt     (hide_evt),
		.page_in_evt  (page_in_evt),
		.page_out_evt (page_out_evt),
		.io_write_evt (io_write_evt)
	);

	mf2_paging_fsm i_paging_fsm (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mode         (mode),
		.freeze_evt   (freeze_evt),
		.vector_evt   (vector_evt),
		.hide_evt     (hide_evt),
		.page_in_evt  (page_in_evt),
		.page_out_evt (page_out_evt),
		.window_sel   (cpu_addr[15:13]),
		.nmi          (nmi),
		.mf2_active   (mf2_active),
		.rom_en       (rom_en),
		.ram_en       (ram_en)
	);

	mf2_shadow_ram i_shadow_ram (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus.shadow),
		.io_write_evt (io_write_evt),
		.ram_en       (ram_en),
		.dout         (dout)
	);

endmodule

`default_nettype wire

// File: bench/tb_multiface_two_sva.sv
// Paging FSM assertions
`timescale 1ns/1ps
`default_nettype none

module tb_multiface_two_sva (
	input wire logic       clk_sys,
	input wire logic       reset,
	input wire logic [1:0] mode,
	input wire logic       vector_evt,
	input wire logic       nmi,
	input wire logic       rom_en,
	input wire logic       ram_en
);

	// Windows never overlap
	assert property (@(posedge clk_sys) disable iff (reset) !(rom_en && ram_en))
		else $error("rom_en and ram_en high together");

	assert property (@(posedge clk_sys) disable iff (reset) (nmi && vector_evt) |=> !nmi)
		else $error("nmi still high after vector fetch");

	// Disabled block stays silent
	assert property (@(posedge clk_sys) disable iff (reset) mode[1] |-> !$rose(nmi))
		else $error("nmi rose while disabled");

endmodule

bind mf2_paging_fsm tb_multiface_two_sva i_sva (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.mode       (mode),
	.vector_evt (vector_evt),
	.nmi        (nmi),
	.rom_en     (rom_en),
	.ram_en     (ram_en)
);

`default_nettype wire

// File: bench/tb_multiface_two.sv
// Multiface Two testbench
`timescale 1ns/1ps
`default_nettype none

module tb_multiface_two;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;
	logic        m1;
	logic        iorq;
	logic        rd;
	logic        wr;
	logic        mem_rd;
	logic        mem_wr;
	logic        key_nmi;
	logic [1:0]  mode;
	logic        nmi;
	logic        mf2_active;
	logic        rom_en;
	logic        ram_en;
	logic [7:0]  dout;

	integer      seed = 32'hbdde_6a41;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          test_errors;
	string       test_name;

	// Reference model
	logic [7:0]  model_mem [8192];
	bit          model_valid [8192];
	logic [4:0]  model_pen;
	logic [3:0]  model_crtc;
	logic [12:0] written [$];

	always #2 clk_sys = ~clk_sys;

	multiface_two i_multiface_two (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.m1         (m1),
		.iorq       (iorq),
		.rd         (rd),
		.wr         (wr),
		.mem_rd     (mem_rd),
		.mem_wr     (mem_wr),
		.key_nmi    (key_nmi),
		.mode       (mode),
		.nmi        (nmi),
		.mf2_active (mf2_active),
		.rom_en     (rom_en),
		.ram_en     (ram_en),
		.dout       (dout)
	);

	//////////////////////////////////////////////////////////////////////
	// Checking and bookkeeping

	task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %s expected %02h actual %02h", name, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = errors;
		tests++;
	endtask

	task automatic end_test();
		$display("test %s: %s", test_name, (errors == test_errors) ? "ok" : "failed");
	endtask

	// Poll nmi (which 0) or mf2_active (which 1)
	task automatic wait_output(input int which, input logic level, input string what);
		int   n;
		logic v;
		n = 0;
		v = ~level;
		while (n < 20 && v !== level) begin
			@(negedge clk_sys);
			v = (which == 0) ? nmi : mf2_active;
			n++;
		end
		if (v !== level) begin
			errors++;
			$display("Timeout: %s did not reach %0d within 20 cycles", what, level);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus cycles

	task automatic apply_reset(input logic [1:0] m);
		@(posedge clk_sys);
		reset  <= 1'b1;
		mode   <= m;
		m1     <= 1'b0;
		iorq   <= 1'b0;
		wr     <= 1'b0;
		mem_rd <= 1'b0;
		mem_wr <= 1'b0;
		key_nmi <= 1'b0;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		model_pen  = '0;
		model_crtc = '0;
		@(posedge clk_sys);
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		cpu_addr <= a;
		cpu_dout <= d;
		iorq     <= 1'b1;
		wr       <= 1'b1;
		@(posedge clk_sys);
		iorq <= 1'b0;
		wr   <= 1'b0;
		@(posedge clk_sys);   // Store lands here
	endtask

	task automatic mem_write(input logic [12:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		cpu_addr <= {3'b001, a};
		cpu_dout <= d;
		mem_wr   <= 1'b1;
		@(posedge clk_sys);
		mem_wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic mem_read(input logic [12:0] a, output logic [7:0] d);
		@(posedge clk_sys);
		cpu_addr <= {3'b001, a};
		mem_rd   <= 1'b1;
		@(posedge clk_sys);
		@(posedge clk_sys);
		@(negedge clk_sys);
		d = dout;
		@(posedge clk_sys);
		mem_rd <= 1'b0;
	endtask

	task automatic fetch(input logic [15:0] a);
		@(posedge clk_sys);
		cpu_addr <= a;
		m1       <= 1'b1;
		@(posedge clk_sys);
		m1 <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic press_freeze();
		@(posedge clk_sys);
		key_nmi <= 1'b1;
		@(posedge clk_sys);
		key_nmi <= 1'b0;
		@(posedge clk_sys);
	endtask

	// Shadow slot rules applied to the model
	task automatic model_io_store(input logic [7:0] port, input logic [7:0] d);
		logic [12:0] slot;
		bit          hit;
		hit  = 1'b1;
		slot = '0;
		if (port == 8'h7f) begin
			case (d[7:6])
				2'b00: slot = 13'h1fcf;
				2'b01: slot = model_pen[4] ? 13'h1fdf : 13'h1f90 + {9'd0, model_pen[3:0]};
				2'b10: slot = 13'h1fef;
				default: slot = 13'h1fff;
			endcase
			if (d[7:6] == 2'b00)
				model_pen = d[4:0];
		end else if (port == 8'hbc) begin
			slot       = 13'h1cff;
			model_crtc = d[3:0];
		end else if (port == 8'hbd)
			slot = 13'h1db0 + {9'd0, model_crtc};
		else if (port == 8'hf7)
			slot = 13'h17ff;
		else if (port == 8'hdf)
			slot = 13'h1aac;
		else
			hit = 1'b0;
		if (hit) begin
			model_mem[slot]   = d;
			model_valid[slot] = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0] r;
		logic [7:0]  port;
		logic [7:0]  got;
		logic [12:0] a;
		int          idx;
		reset    = 1'b1;
		cpu_addr = '0;
		cpu_dout = '0;
		m1       = 1'b0;
		iorq     = 1'b0;
		rd       = 1'b0;
		wr       = 1'b0;
		mem_rd   = 1'b0;
		mem_wr   = 1'b0;
		key_nmi  = 1'b0;
		mode     = 2'd0;
		model_pen  = '0;
		model_crtc = '0;

		begin_test("reset");
		apply_reset(2'd0);
		@(negedge clk_sys);
		check("reset nmi", 8'h00, 8'(nmi));
		check("reset active", 8'h00, 8'(mf2_active));
		check("reset rom_en", 8'h00, 8'(rom_en));
		check("reset ram_en", 8'h00, 8'(ram_en));
		mem_read(13'h0123, got);
		check("reset dout", 8'hff, got);
		end_test();

		begin_test("freeze");
		press_freeze();
		wait_output(0, 1'b1, "nmi");
		fetch(16'h0066);
		wait_output(1, 1'b1, "mf2_active");
		check("nmi after vector", 8'h00, 8'(nmi));
		@(posedge clk_sys) cpu_addr <= 16'h1234;
		@(negedge clk_sys);
		check("rom window rom_en", 8'h01, 8'(rom_en));
		check("rom window ram_en", 8'h00, 8'(ram_en));
		@(posedge clk_sys) cpu_addr <= 16'h2345;
		@(negedge clk_sys);
		check("ram window ram_en", 8'h01, 8'(ram_en));
		check("ram window rom_en", 8'h00, 8'(rom_en));
		@(posedge clk_sys) cpu_addr <= 16'h4000;
		@(negedge clk_sys);
		check("outside windows", 8'h00, {6'd0, rom_en, ram_en});
		end_test();

		begin_test("io paging");
		io_write(16'hfeea, 8'h00);
		wait_output(1, 1'b0, "page out");
		io_write(16'hfee8, 8'h00);
		wait_output(1, 1'b1, "page in");
		fetch(16'h0065);   // Now hidden
		io_write(16'hfeea, 8'h00);
		wait_output(1, 1'b0, "hidden page out");
		io_write(16'hfee8, 8'h00);
		repeat (3) @(negedge clk_sys);
		check("hidden page in ignored", 8'h00, 8'(mf2_active));
		press_freeze();
		wait_output(0, 1'b1, "nmi after hide");
		fetch(16'h0066);
		wait_output(1, 1'b1, "active after hide");
		end_test();

		begin_test("modes");
		apply_reset(2'd1);
		io_write(16'hfee8, 8'h00);
		repeat (3) @(negedge clk_sys);
		check("mode 1 page in", 8'h00, 8'(mf2_active));
		press_freeze();
		wait_output(0, 1'b1, "mode 1 nmi");
		fetch(16'h0066);
		wait_output(1, 1'b1, "mode 1 active");
		apply_reset(2'd2);
		press_freeze();
		repeat (3) @(negedge clk_sys);
		check("mode 2 nmi", 8'h00, 8'(nmi));
		io_write(16'hfee8, 8'h00);
		repeat (3) @(negedge clk_sys);
		check("mode 2 page in", 8'h00, 8'(mf2_active));
		end_test();

		begin_test("shadow");
		apply_reset(2'd0);
		io_write(16'hfee8, 8'h00);
		wait_output(1, 1'b1, "shadow page in");
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			case (r[2:0])
				3'd0: port = 8'h7f;
				3'd1: port = 8'hbc;
				3'd2: port = 8'hbd;
				3'd3: port = 8'hf7;
				3'd4: port = 8'hdf;
				3'd5: port = 8'hfb;   // No slot
				3'd6: port = 8'hef;
				default: port = 8'h10;
			endcase
			io_write({port, r[15:8]}, r[23:16]);
			model_io_store(port, r[23:16]);
		end
		for (int s = 0; s < 8192; s++) begin
			if (model_valid[s]) begin
				mem_read(13'(s), got);
				check("shadow slot", model_mem[s], got);
			end
		end
		end_test();

		begin_test("ram window");
		for (int i = 0; i < 64; i++) begin
			r = $random(seed);
			mem_write(r[12:0], r[23:16]);
			model_mem[r[12:0]]   = r[23:16];
			model_valid[r[12:0]] = 1'b1;
			written.push_back(r[12:0]);
		end
		for (int i = 0; i < 64; i++) begin
			r = $random(seed);
			idx = int'(r[15:0]) % written.size();
			a = written[idx];
			mem_read(a, got);
			check("ram read", model_mem[a], got);
		end
		io_write(16'hfeea, 8'h00);
		wait_output(1, 1'b0, "ram page out");
		for (int i = 0; i < 32; i++) begin
			r = $random(seed);
			idx = int'(r[15:0]) % written.size();
			a = written[idx];
			mem_write(a, ~model_mem[a]);   // Must not land
			mem_read(a, got);
			check("paged out read", 8'hff, got);
		end
		io_write(16'hfee8, 8'h00);
		wait_output(1, 1'b1, "ram page in");
		foreach (written[i]) begin
			mem_read(written[i], got);
			check("ram after page out", model_mem[written[i]], got);
		end
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
src/mf2_pkg.sv
src/mf2_bus_if.sv
src/mf2_bus_monitor.sv
src/mf2_paging_fsm.sv
src/mf2_shadow_ram.sv
src/multiface_two.sv
bench/tb_multiface_two_sva.sv
bench/tb_multiface_two.sv

// File: Makefile
# Verilator build for the Multiface Two block

VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0
TOP        ?= tb_multiface_two
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
